// File: common/rv_fetch_buf_if.sv
`timescale 1ns/1ps

interface rv_fetch_buf_if
    import rv_fetch_pkg::*;
(
    input logic clk
);

    // halfword address of the first parcel in the current push
    iaddr_t     push_pc;
    parcel_t    data_lo;
    parcel_t    data_hi;
    // single pushes data_hi only, double pushes data_lo then data_hi
    logic       push_single;
    logic       push_double;
    // empties the buffer, wins over any push on the same edge
    logic       flush;
    // room for two more parcels once the current push has landed
    logic       not_full;

    modport producer
    (
        input  clk,
        output push_pc,
        output data_lo,
        output data_hi,
        output push_single,
        output push_double,
        output flush,
        input  not_full
    );

    modport consumer
    (
        input  clk,
        input  push_pc,
        input  data_lo,
        input  data_hi,
        input  push_single,
        input  push_double,
        input  flush,
        output not_full
    );

endinterface

// File: common/rv_fetch_pkg.sv
package rv_fetch_pkg;

    // byte address space of the instruction bus
    localparam int IADDR_BITS = 16;

    // halfword address, bit 0 is always zero and not carried
    typedef logic [IADDR_BITS-1:1] iaddr_t;

    // one 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // instruction word as seen by decode
    typedef logic [31:0] instr_t;

    // pc after reset
    localparam iaddr_t RESET_ADDR = '0;

    // pc steps in halfword units
    localparam iaddr_t PC_STEP_HALF = iaddr_t'(1);
    localparam iaddr_t PC_STEP_WORD = iaddr_t'(2);

    // low opcode bits of a full 32-bit instruction
    localparam logic [1:0] OPC_FULL = 2'b11;

    // parcel buffer geometry
    localparam int BUF_DEPTH_BITS = 2;
    localparam int BUF_DEPTH = 2 ** BUF_DEPTH_BITS;

    // buffer slot index, wraps around the store
    typedef logic [BUF_DEPTH_BITS-1:0] buf_ptr_t;

    // fill level, one bit wider so a full store can be told from an empty one
    typedef logic [BUF_DEPTH_BITS:0] buf_cnt_t;

    // parcels per push or pop
    localparam buf_cnt_t CNT_ONE = buf_cnt_t'(1);
    localparam buf_cnt_t CNT_TWO = buf_cnt_t'(2);

endpackage

// File: compile.f
common/rv_fetch_pkg.sv
common/rv_fetch_buf_if.sv
fetch/rv_fetch.sv
fetch/rv_fetch_buf.sv
design/rv_fetch_top.sv
sim/rv_fetch_checker.sv
sim/tb_rv_fetch.sv

// File: design/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top
    import rv_fetch_pkg::*;
(
    input  logic    clk,
    input  logic    i_arst_n,
    input  logic    i_stall,
    input  logic    i_pc_select,
    input  iaddr_t  i_pc_target,
    input  logic    i_trap,
    input  iaddr_t  i_trap_pc,
    input  instr_t  i_instruction,
    input  logic    i_ack,
    output logic    o_cyc,
    output iaddr_t  o_addr,
    output logic    o_pc_change,
    output logic    o_ready,
    output instr_t  o_instr,
    output iaddr_t  o_pc,
    output iaddr_t  o_pc_next
);

    logic buf_pop;

    rv_fetch_buf_if bif
    (
        .clk            (clk)
    );

    // decode takes the head instruction unless it holds back
    assign buf_pop = o_ready & ~i_stall;

    rv_fetch u_fetch
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_trap         (i_trap),
        .i_trap_pc      (i_trap_pc),
        .i_ack          (i_ack),
        .i_instruction  (i_instruction),
        .o_cyc          (o_cyc),
        .o_addr         (o_addr),
        .o_pc_change    (o_pc_change),
        .bif            (bif.producer)
    );

    rv_fetch_buf u_buf
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .bif            (bif.consumer),
        .i_pop          (buf_pop),
        .o_ready        (o_ready),
        .o_instr        (o_instr),
        .o_pc           (o_pc),
        .o_pc_next      (o_pc_next)
    );

endmodule

// File: fetch/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
    import rv_fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_pc_select,
    input  iaddr_t                  i_pc_target,
    input  logic                    i_trap,
    input  iaddr_t                  i_trap_pc,
    input  logic                    i_ack,
    input  instr_t                  i_instruction,
    output logic                    o_cyc,
    output iaddr_t                  o_addr,
    output logic                    o_pc_change,
    rv_fetch_buf_if.producer        bif
);

    iaddr_t pc;
    iaddr_t pc_incr;
    iaddr_t pc_sum;
    logic   change_pc;
    logic   move_pc;

    // pc of the word whose data arrives this cycle
    iaddr_t req_pc;
    logic   push_pending;
    logic   push_live;

    // either redirect input moves the pc
    assign change_pc = i_trap | i_pc_select;

    // a read is wanted whenever the buffer can take a whole word
    assign o_cyc = bif.not_full;
    assign o_addr = pc;

    // word accepted by memory on this edge
    assign move_pc = i_ack & o_cyc;

    // half-aligned pc only gets the upper parcel and steps back onto a word
    assign pc_incr = pc[1] ? PC_STEP_HALF : PC_STEP_WORD;
    assign pc_sum = pc + pc_incr;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc <= RESET_ADDR;
        end
        else if (i_trap)
        begin
            pc <= i_trap_pc;
        end
        else if (i_pc_select)
        begin
            pc <= i_pc_target;
        end
        else if (move_pc)
        begin
            pc <= pc_sum;
        end
    end

    // a word acked during a redirect belongs to the old stream
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            push_pending <= 1'b0;
        end
        else
        begin
            push_pending <= move_pc & ~change_pc;
        end
    end

    // request address travels one cycle behind the ack along with its data
    always_ff @(posedge clk)
    begin
        if (move_pc)
        begin
            req_pc <= pc;
        end
    end

    // data of the previous ack is killed if a redirect shows up now
    assign push_live = push_pending & ~change_pc;

    assign bif.push_pc = req_pc;
    assign bif.data_lo = i_instruction[15:0];
    assign bif.data_hi = i_instruction[31:16];

    // bit 1 of the requested pc tells whether the lower parcel is wanted
    assign bif.push_single = push_live & req_pc[1];
    assign bif.push_double = push_live & ~req_pc[1];

    assign bif.flush = change_pc;
    assign o_pc_change = change_pc;

    // memory only answers an outstanding request
    a_ack_needs_cyc : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_ack |-> o_cyc
    );

endmodule

// File: fetch/rv_fetch_buf.sv
`timescale 1ns/1ps

module rv_fetch_buf
    import rv_fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_arst_n,
    rv_fetch_buf_if.consumer        bif,
    input  logic                    i_pop,
    output logic                    o_ready,
    output instr_t                  o_instr,
    output iaddr_t                  o_pc,
    output iaddr_t                  o_pc_next
);

    // circular parcel store
    parcel_t  mem [BUF_DEPTH];
    buf_ptr_t rd_ptr;
    buf_ptr_t wr_ptr;
    buf_cnt_t count;

    // pc of the parcel at rd_ptr, valid once a push followed a flush
    iaddr_t   head_pc;
    logic     head_pc_valid;

    parcel_t  head_lo;
    parcel_t  head_hi;
    logic     head_is_comp;

    logic     do_push;
    buf_cnt_t push_cnt;
    logic     do_pop;
    buf_cnt_t pop_cnt;
    iaddr_t   pc_step;

    assign head_lo = mem[rd_ptr];
    assign head_hi = mem[rd_ptr + buf_ptr_t'(1)];

    // compressed unless both low opcode bits are set
    assign head_is_comp = (head_lo[1:0] != OPC_FULL);

    // a whole instruction sits at the head
    assign o_ready = ((count >= CNT_ONE) && head_is_comp) || (count >= CNT_TWO);

    assign o_instr = head_is_comp ? {16'h0000, head_lo} : {head_hi, head_lo};

    assign pc_step = head_is_comp ? PC_STEP_HALF : PC_STEP_WORD;
    assign o_pc = head_pc;
    assign o_pc_next = head_pc + pc_step;

    // flush drops whatever arrives in the same cycle
    assign do_push = (bif.push_single | bif.push_double) & ~bif.flush;
    assign push_cnt = !do_push ? '0 : (bif.push_double ? CNT_TWO : CNT_ONE);

    assign do_pop = i_pop & o_ready;
    assign pop_cnt = !do_pop ? '0 : (head_is_comp ? CNT_ONE : CNT_TWO);

    // counts the push in flight so the next acked word is sure to fit
    assign bif.not_full = (count + push_cnt) <= buf_cnt_t'(BUF_DEPTH - 2);

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            if (bif.push_double)
            begin
                mem[wr_ptr] <= bif.data_lo;
                mem[wr_ptr + buf_ptr_t'(1)] <= bif.data_hi;
            end
            else
            begin
                mem[wr_ptr] <= bif.data_hi;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else if (bif.flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            wr_ptr <= wr_ptr + buf_ptr_t'(push_cnt);
            rd_ptr <= rd_ptr + buf_ptr_t'(pop_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    // head pc restarts from the first push of a new stream
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            head_pc <= RESET_ADDR;
            head_pc_valid <= 1'b0;
        end
        else if (bif.flush)
        begin
            head_pc_valid <= 1'b0;
        end
        else if (do_push && !head_pc_valid)
        begin
            head_pc <= bif.push_pc;
            head_pc_valid <= 1'b1;
        end
        else if (do_pop)
        begin
            head_pc <= o_pc_next;
        end
    end

    // store never overflows
    a_count_bound : assert property (
        @(posedge clk) disable iff (!i_arst_n)
        count <= buf_cnt_t'(BUF_DEPTH)
    );

    // a push is the data of a word requested while there was room
    a_push_had_room : assert property (
        @(posedge bif.clk) disable iff (!i_arst_n)
        (bif.push_single || bif.push_double) |-> $past(bif.not_full)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv_fetch \
    -f compile.f \
    -o tb_rv_fetch

./obj_dir/tb_rv_fetch | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"

// File: sim/rv_fetch_checker.sv
`timescale 1ns/1ps

module rv_fetch_checker
    import rv_fetch_pkg::*;
#(
    parameter int MEM_WORDS = 64
)
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  instr_t      i_mem [MEM_WORDS],
    input  logic        i_stall,
    input  logic        i_pc_select,
    input  iaddr_t      i_pc_target,
    input  logic        i_trap,
    input  iaddr_t      i_trap_pc,
    input  logic        i_ack,
    input  logic        i_cyc,
    input  iaddr_t      i_addr,
    input  logic        i_pc_change,
    input  logic        i_ready,
    input  instr_t      i_instr,
    input  iaddr_t      i_pc,
    input  iaddr_t      i_pc_next,
    output int unsigned o_errors,
    output int unsigned o_accepted,
    output int unsigned o_cyc_low
);

    localparam int MEM_BITS = $clog2(MEM_WORDS);

    iaddr_t      exp_pc;
    logic        ack_seen;
    int unsigned errors = 0;
    int unsigned accepted = 0;
    int unsigned cyc_low = 0;

    assign o_errors = errors;
    assign o_accepted = accepted;
    assign o_cyc_low = cyc_low;

    // memory ignores address bit 1 and wraps at the end of the table
    function automatic parcel_t parcel_at(input iaddr_t addr);
        instr_t word;
        word = i_mem[addr[MEM_BITS+1:2]];
        return addr[1] ? word[31:16] : word[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // sampled mid cycle, an accept takes effect on the following rising edge
    always @(negedge clk)
    begin : watch
        parcel_t lo;
        instr_t  exp_instr;
        iaddr_t  exp_next;
        if (!i_arst_n)
        begin
            exp_pc = RESET_ADDR;
            ack_seen = 1'b0;
        end
        else
        begin
            // empty buffer keeps requesting the reset address
            if (!ack_seen)
            begin
                check_value("o_ready", 32'(1'b0), 32'(i_ready));
                check_value("o_cyc", 32'(1'b1), 32'(i_cyc));
                check_value("o_addr", 32'(RESET_ADDR), 32'(i_addr));
            end
            check_value("o_pc_change", 32'(i_trap | i_pc_select), 32'(i_pc_change));
            if (!i_cyc)
            begin
                cyc_low++;
            end
            if (i_ready && !i_stall)
            begin
                lo = parcel_at(exp_pc);
                if (lo[1:0] != 2'b11)
                begin
                    exp_instr = {16'h0000, lo};
                    exp_next = exp_pc + iaddr_t'(1);
                end
                else
                begin
                    exp_instr = {parcel_at(exp_pc + iaddr_t'(1)), lo};
                    exp_next = exp_pc + iaddr_t'(2);
                end
                check_value("o_instr", exp_instr, i_instr);
                check_value("o_pc", 32'(exp_pc), 32'(i_pc));
                check_value("o_pc_next", 32'(exp_next), 32'(i_pc_next));
                accepted++;
                exp_pc = exp_next;
            end
            // trap wins over a branch in the same cycle
            if (i_trap)
            begin
                exp_pc = i_trap_pc;
            end
            else if (i_pc_select)
            begin
                exp_pc = i_pc_target;
            end
            if (i_ack)
            begin
                ack_seen = 1'b1;
            end
        end
    end

endmodule

// File: sim/tb_rv_fetch.sv
`timescale 1ns/1ps

module tb_rv_fetch
    import rv_fetch_pkg::*;
();

    localparam int MEM_WORDS = 64;
    localparam int MEM_BITS = $clog2(MEM_WORDS);
    localparam logic [31:0] LFSR_SEED = 32'h8c5eec14;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int NUM_ROWS = 9;
    localparam int TIMEOUT_SLACK = 200;

    typedef enum logic [1:0] { RD_NONE, RD_BRANCH, RD_TRAP } redirect_t;

    // stall chance in sixteenths, target is a byte address
    typedef struct packed {
        logic [15:0] run_len;
        logic [4:0]  stall_16ths;
        redirect_t   kind;
        logic [15:0] target;
    } stim_row_t;

    logic        clk;
    logic        i_arst_n;
    logic        i_stall;
    logic        i_pc_select;
    iaddr_t      i_pc_target;
    logic        i_trap;
    iaddr_t      i_trap_pc;
    instr_t      i_instruction;
    logic        i_ack;
    logic        o_cyc;
    iaddr_t      o_addr;
    logic        o_pc_change;
    logic        o_ready;
    instr_t      o_instr;
    iaddr_t      o_pc;
    iaddr_t      o_pc_next;

    logic        ack_grant;
    logic [4:0]  stall_16ths;
    instr_t      mem_table [MEM_WORDS];
    stim_row_t   stim_table [NUM_ROWS];
    int unsigned value_errs;
    int unsigned accepted;
    int unsigned cyc_low;
    int unsigned end_errs;

    rv_fetch_top uut
    (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_stall        (i_stall),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_trap         (i_trap),
        .i_trap_pc      (i_trap_pc),
        .i_instruction  (i_instruction),
        .i_ack          (i_ack),
        .o_cyc          (o_cyc),
        .o_addr         (o_addr),
        .o_pc_change    (o_pc_change),
        .o_ready        (o_ready),
        .o_instr        (o_instr),
        .o_pc           (o_pc),
        .o_pc_next      (o_pc_next)
    );

    rv_fetch_checker #(.MEM_WORDS(MEM_WORDS)) u_check
    (
        .clk(clk), .i_arst_n(i_arst_n), .i_mem(mem_table), .i_stall(i_stall),
        .i_pc_select(i_pc_select), .i_pc_target(i_pc_target), .i_trap(i_trap),
        .i_trap_pc(i_trap_pc), .i_ack(i_ack), .i_cyc(o_cyc), .i_addr(o_addr),
        .i_pc_change(o_pc_change), .i_ready(o_ready), .i_instr(o_instr), .i_pc(o_pc),
        .i_pc_next(o_pc_next), .o_errors(value_errs), .o_accepted(accepted),
        .o_cyc_low(cyc_low)
    );

    // memory acks only an open request
    assign i_ack = o_cyc & ack_grant;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++)
        begin
            bits[i] = state[0];
            state = lfsr_step(state);
        end
    endtask

    task automatic load_stimulus();
        stim_table[0] = '{16'd60, 5'd0, RD_NONE, 16'h0000};
        stim_table[1] = '{16'd40, 5'd4, RD_BRANCH, 16'h0042};
        stim_table[2] = '{16'd50, 5'd8, RD_BRANCH, 16'h0080};
        stim_table[3] = '{16'd30, 5'd0, RD_TRAP, 16'h00a6};
        stim_table[4] = '{16'd80, 5'd15, RD_NONE, 16'h0000};
        // half-aligned at the last halfword, a 32-bit instruction wraps to word 0
        stim_table[5] = '{16'd40, 5'd2, RD_BRANCH, 16'h00fe};
        stim_table[6] = '{16'd60, 5'd10, RD_TRAP, 16'h0012};
        stim_table[7] = '{16'd50, 5'd0, RD_BRANCH, 16'h0006};
        stim_table[8] = '{16'd60, 5'd6, RD_NONE, 16'h0000};
    endtask

    function automatic int unsigned total_run_cycles();
        int unsigned sum;
        int r;
        sum = 0;
        for (r = 0; r < NUM_ROWS; r++)
        begin
            sum = sum + 32'(stim_table[r].run_len);
        end
        return sum;
    endfunction

    // a trap row also raises a branch to another target, the trap must win
    task automatic apply_redirect(input stim_row_t row);
        if (row.kind != RD_NONE)
        begin
            i_pc_select <= 1'b1;
            if (row.kind == RD_TRAP)
            begin
                i_trap <= 1'b1;
                i_trap_pc <= row.target[15:1];
                i_pc_target <= row.target[15:1] + iaddr_t'(9);
            end
            else
            begin
                i_pc_target <= row.target[15:1];
            end
            @(posedge clk);
            i_pc_select <= 1'b0;
            i_trap <= 1'b0;
        end
    endtask

    // owns the lfsr: fills the table first, then draws ack and stall bits
    initial
    begin : memory_model
        logic [31:0] lfsr;
        logic [31:0] bits;
        parcel_t     parcel;
        int          w;
        int          h;
        lfsr = LFSR_SEED;
        ack_grant = 1'b0;
        i_stall = 1'b0;
        i_instruction = '0;
        for (w = 0; w < MEM_WORDS; w++)
        begin
            for (h = 0; h < 2; h++)
            begin
                draw_bits(lfsr, 16, bits);
                parcel = bits[15:0];
                draw_bits(lfsr, 1, bits);
                if (bits[0])
                begin
                    parcel[1:0] = 2'b11;
                end
                mem_table[w][16*h +: 16] = parcel;
            end
        end
        forever
        begin
            @(posedge clk);
            if (i_ack)
            begin
                i_instruction <= mem_table[o_addr[MEM_BITS+1:2]];
            end
            draw_bits(lfsr, 1, bits);
            ack_grant <= bits[0];
            draw_bits(lfsr, 4, bits);
            i_stall <= ({1'b0, bits[3:0]} < stall_16ths);
        end
    end

    initial
    begin : stimulus
        int          row;
        int unsigned start;
        i_arst_n = 1'b0;
        i_pc_select = 1'b0;
        i_pc_target = '0;
        i_trap = 1'b0;
        i_trap_pc = '0;
        stall_16ths = '0;
        end_errs = 0;
        load_stimulus();
        repeat (3) @(posedge clk);
        i_arst_n <= 1'b1;
        for (row = 0; row < NUM_ROWS; row++)
        begin
            stall_16ths <= stim_table[row].stall_16ths;
            repeat (stim_table[row].run_len) @(posedge clk);
            apply_redirect(stim_table[row]);
        end
        // drain with stalls off, the stream must still move
        stall_16ths <= '0;
        start = accepted;
        while (accepted < start + 4)
        begin
            @(posedge clk);
        end
        if (cyc_low == 0)
        begin
            $display("o_cyc never dropped, stalls did not fill the buffer");
            end_errs++;
        end
        $display("checked %0d instructions, %0d value errors, %0d other errors",
                 accepted, value_errs, end_errs);
        if ((value_errs == 0) && (end_errs == 0))
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    initial
    begin : watchdog
        int unsigned limit;
        int unsigned cycles;
        @(posedge i_arst_n);
        limit = total_run_cycles() + TIMEOUT_SLACK;
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run hung, the test did not finish within %0d cycles", limit);
        $display("checked %0d instructions, %0d value errors, %0d other errors",
                 accepted, value_errs, end_errs + 1);
        $display("Regression failed");
        $finish;
    end

endmodule
